// ==== design/rtcPkg.sv ====
`default_nettype none

package rtcPkg;

	// the chip bus is 8 bits wide, shared by address and data
	typedef logic [7:0] rtcAddr_t;
	typedef logic [7:0] rtcData_t;

	// index into the local copy of the time registers
	typedef logic [2:0] regIndex_t;

	// seconds, minutes, hours, day, month, year
	localparam int NUM_TIME_REGS = 6;
	localparam rtcAddr_t TIME_BASE_ADDR = 8'h21;

	// control gets 0x10 first, then status is cleared,
	// then control is released back to normal operation
	localparam int INIT_LEN = 3;
	localparam rtcAddr_t INIT_ADDRS [INIT_LEN] = '{8'h02, 8'h01, 8'h02};
	localparam rtcData_t INIT_DATA [INIT_LEN] = '{8'h10, 8'h00, 8'h00};

endpackage

`default_nettype wire

// ==== design/rtcBusPhy.sv ====
`default_nettype none

module rtcBusPhy #(
	parameter int PHASE_CYCLES = 2
) (
	input logic clk,
	input logic reset,
	input logic busStart,
	input logic busWrite,
	input rtcPkg::rtcAddr_t busAddr,
	input rtcPkg::rtcData_t busWdata,
	output rtcPkg::rtcData_t busRdata,
	output logic busDone,
	output logic csN,
	output logic adN,
	output logic rdN,
	output logic wrN,
	output rtcPkg::rtcData_t busOut,
	output logic busOe,
	input rtcPkg::rtcData_t busIn
);
	import rtcPkg::*;

	localparam int CNT_W = $clog2(PHASE_CYCLES + 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PHASE_CYCLES - 1);

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		GAP,
		DATA,
		RECOVER
	} phase_t;

	phase_t phase;
	phase_t nextPhase;
	logic [CNT_W-1:0] phaseCnt;
	logic phaseEnd;
	logic isWrite;
	rtcAddr_t addrReg;
	rtcData_t dataReg;

	assign phaseEnd = (phaseCnt == LAST_CNT);

	// phases always run in the same order
	always_comb begin
		case (phase)
			ADDR: nextPhase = GAP;
			GAP: nextPhase = DATA;
			DATA: nextPhase = RECOVER;
			default: nextPhase = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= IDLE;
			phaseCnt <= '0;
			isWrite <= 1'b0;
		end else if (phase == IDLE) begin
			phaseCnt <= '0;
			// requests are only taken while idle
			if (busStart) begin
				phase <= ADDR;
				isWrite <= busWrite;
			end
		end else if (phaseEnd) begin
			phaseCnt <= '0;
			phase <= nextPhase;
		end else begin
			phaseCnt <= phaseCnt + 1'b1;
		end
	end

	// transaction payload
	always_ff @(posedge clk) begin
		if (phase == IDLE && busStart) begin
			addrReg <= busAddr;
			dataReg <= busWdata;
		end
		// sample on the last cycle of the read strobe
		if (phase == DATA && phaseEnd && !isWrite) begin
			busRdata <= busIn;
		end
	end

	always_comb begin
		csN = 1'b1;
		adN = 1'b1;
		rdN = 1'b1;
		wrN = 1'b1;
		busOe = 1'b0;
		busOut = addrReg;
		case (phase)
			ADDR: begin
				csN = 1'b0;
				adN = 1'b0;
				busOe = 1'b1;
			end
			GAP: begin
				csN = 1'b0;
			end
			DATA: begin
				csN = 1'b0;
				if (isWrite) begin
					wrN = 1'b0;
					busOe = 1'b1;
					busOut = dataReg;
				end else begin
					// bus released so the chip can drive it
					rdN = 1'b0;
				end
			end
			default: begin
			end
		endcase
	end

	assign busDone = (phase == RECOVER) && phaseEnd;

endmodule

`default_nettype wire

// ==== design/rtcInit.sv ====
`default_nettype none

module rtcInit (
	input logic clk,
	input logic reset,
	input logic start,
	output logic busStart,
	output rtcPkg::rtcAddr_t busAddr,
	output rtcPkg::rtcData_t busWdata,
	input logic busDone,
	output logic finish
);
	import rtcPkg::*;

	localparam int STEP_W = $clog2(INIT_LEN);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(INIT_LEN - 1);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT
	} initState_t;

	initState_t state;
	logic [STEP_W-1:0] step;
	logic lastStep;

	assign lastStep = (step == LAST_STEP);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			step <= '0;
		end else begin
			case (state)
				IDLE: begin
					step <= '0;
					if (start) begin
						state <= ISSUE;
					end
				end
				ISSUE: begin
					state <= WAIT;
				end
				WAIT: begin
					if (busDone) begin
						if (lastStep) begin
							state <= IDLE;
						end else begin
							step <= step + 1'b1;
							state <= ISSUE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// one write per table entry
	assign busStart = (state == ISSUE);
	assign busAddr = INIT_ADDRS[step];
	assign busWdata = INIT_DATA[step];
	assign finish = (state == WAIT) && busDone && lastStep;

endmodule

`default_nettype wire

// ==== design/rtcPoller.sv ====
`default_nettype none

module rtcPoller (
	input logic clk,
	input logic reset,
	input logic start,
	output logic busStart,
	output rtcPkg::rtcAddr_t busAddr,
	input logic busDone,
	input rtcPkg::rtcData_t busRdata,
	output logic shadowWrite,
	output rtcPkg::regIndex_t shadowIndex,
	output rtcPkg::rtcData_t shadowData,
	output logic finish
);
	import rtcPkg::*;

	localparam regIndex_t LAST_INDEX = regIndex_t'(NUM_TIME_REGS - 1);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT
	} pollState_t;

	pollState_t state;
	regIndex_t index;
	logic readDone;

	assign readDone = (state == WAIT) && busDone;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			index <= '0;
		end else begin
			case (state)
				IDLE: begin
					index <= '0;
					if (start) begin
						state <= ISSUE;
					end
				end
				ISSUE: begin
					state <= WAIT;
				end
				WAIT: begin
					if (busDone) begin
						if (index == LAST_INDEX) begin
							state <= IDLE;
						end else begin
							index <= index + 1'b1;
							state <= ISSUE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign busStart = (state == ISSUE);
	assign busAddr = TIME_BASE_ADDR + rtcAddr_t'(index);

	// read data is valid in the busDone cycle, store it right away
	assign shadowWrite = readDone;
	assign shadowIndex = index;
	assign shadowData = busRdata;
	assign finish = readDone && (index == LAST_INDEX);

endmodule

`default_nettype wire

// ==== design/rtcSequencer.sv ====
`default_nettype none

module rtcSequencer (
	input logic clk,
	input logic reset,
	input logic userWrite,
	input rtcPkg::rtcAddr_t userAddr,
	input rtcPkg::rtcData_t userData,
	output logic userAck,
	output logic initDone,
	output logic sweepDone,
	output logic busStart,
	output logic busWrite,
	output rtcPkg::rtcAddr_t busAddr,
	output rtcPkg::rtcData_t busWdata,
	input logic busDone,
	input rtcPkg::rtcData_t busRdata,
	output logic shadowWrite,
	output rtcPkg::regIndex_t shadowIndex,
	output rtcPkg::rtcData_t shadowData
);
	import rtcPkg::*;

	typedef enum logic [2:0] {
		INIT_START,
		INIT_RUN,
		SWEEP_START,
		SWEEP_RUN,
		USER_ISSUE,
		USER_WAIT
	} seqState_t;

	seqState_t state;

	logic initStart;
	logic initBusStart;
	rtcAddr_t initBusAddr;
	rtcData_t initBusWdata;
	logic initBusDone;
	logic initFinish;

	logic pollStart;
	logic pollBusStart;
	rtcAddr_t pollBusAddr;
	logic pollBusDone;
	logic pollFinish;

	rtcInit initSeq (
		.clk(clk),
		.reset(reset),
		.start(initStart),
		.busStart(initBusStart),
		.busAddr(initBusAddr),
		.busWdata(initBusWdata),
		.busDone(initBusDone),
		.finish(initFinish)
	);

	rtcPoller poller (
		.clk(clk),
		.reset(reset),
		.start(pollStart),
		.busStart(pollBusStart),
		.busAddr(pollBusAddr),
		.busDone(pollBusDone),
		.busRdata(busRdata),
		.shadowWrite(shadowWrite),
		.shadowIndex(shadowIndex),
		.shadowData(shadowData),
		.finish(pollFinish)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= INIT_START;
			initDone <= 1'b0;
		end else begin
			case (state)
				INIT_START: state <= INIT_RUN;
				INIT_RUN: begin
					if (initFinish) begin
						initDone <= 1'b1;
						state <= SWEEP_START;
					end
				end
				SWEEP_START: state <= SWEEP_RUN;
				SWEEP_RUN: begin
					// user requests are only looked at between sweeps
					if (pollFinish) begin
						state <= userWrite ? USER_ISSUE : SWEEP_START;
					end
				end
				USER_ISSUE: state <= USER_WAIT;
				USER_WAIT: begin
					if (busDone) begin
						state <= SWEEP_START;
					end
				end
				default: state <= INIT_START;
			endcase
		end
	end

	assign initStart = (state == INIT_START);
	assign pollStart = (state == SWEEP_START);

	// done goes back only to whoever owns the bus
	assign initBusDone = busDone && (state == INIT_RUN);
	assign pollBusDone = busDone && (state == SWEEP_RUN);
	assign sweepDone = pollFinish;
	assign userAck = busDone && (state == USER_WAIT);

	// request mux toward the bus engine
	always_comb begin
		busStart = 1'b0;
		busWrite = 1'b0;
		busAddr = pollBusAddr;
		busWdata = '0;
		case (state)
			INIT_RUN: begin
				busStart = initBusStart;
				busWrite = 1'b1;
				busAddr = initBusAddr;
				busWdata = initBusWdata;
			end
			SWEEP_RUN: begin
				busStart = pollBusStart;
			end
			USER_ISSUE: begin
				busStart = 1'b1;
				busWrite = 1'b1;
				busAddr = userAddr;
				busWdata = userData;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rtcShadowRegs.sv ====
`default_nettype none

module rtcShadowRegs (
	input logic clk,
	input logic reset,
	input logic writeEn,
	input rtcPkg::regIndex_t writeIndex,
	input rtcPkg::rtcData_t writeData,
	input rtcPkg::regIndex_t readIndex,
	output rtcPkg::rtcData_t readData
);
	import rtcPkg::*;

	// local copy of the chip time, seconds first
	rtcData_t timeRegs [NUM_TIME_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_TIME_REGS; i++) begin
				timeRegs[i] <= '0;
			end
		end else if (writeEn && (writeIndex < NUM_TIME_REGS)) begin
			timeRegs[writeIndex] <= writeData;
		end
	end

	// indices past the last register read as zero
	assign readData = (readIndex < NUM_TIME_REGS) ? timeRegs[readIndex] : '0;

endmodule

`default_nettype wire

// ==== design/rtcController.sv ====
`default_nettype none

module rtcController #(
	parameter int PHASE_CYCLES = 2
) (
	input logic clk,
	input logic reset,
	output logic csN,
	output logic adN,
	output logic rdN,
	output logic wrN,
	inout wire rtcPkg::rtcData_t dataBus,
	input logic userWrite,
	input rtcPkg::rtcAddr_t userAddr,
	input rtcPkg::rtcData_t userData,
	output logic userAck,
	input rtcPkg::regIndex_t readIndex,
	output rtcPkg::rtcData_t readData,
	output logic initDone,
	output logic sweepDone
);
	import rtcPkg::*;

	logic busStart;
	logic busWrite;
	rtcAddr_t busAddr;
	rtcData_t busWdata;
	rtcData_t busRdata;
	logic busDone;
	rtcData_t busOut;
	logic busOe;
	rtcData_t busIn;

	logic shadowWrite;
	regIndex_t shadowIndex;
	rtcData_t shadowData;

	// pad toward the chip
	assign dataBus = busOe ? busOut : 'z;
	assign busIn = dataBus;

	rtcSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.userWrite(userWrite),
		.userAddr(userAddr),
		.userData(userData),
		.userAck(userAck),
		.initDone(initDone),
		.sweepDone(sweepDone),
		.busStart(busStart),
		.busWrite(busWrite),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.busDone(busDone),
		.busRdata(busRdata),
		.shadowWrite(shadowWrite),
		.shadowIndex(shadowIndex),
		.shadowData(shadowData)
	);

	rtcBusPhy #(
		.PHASE_CYCLES(PHASE_CYCLES)
	) busPhy (
		.clk(clk),
		.reset(reset),
		.busStart(busStart),
		.busWrite(busWrite),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.busRdata(busRdata),
		.busDone(busDone),
		.csN(csN),
		.adN(adN),
		.rdN(rdN),
		.wrN(wrN),
		.busOut(busOut),
		.busOe(busOe),
		.busIn(busIn)
	);

	rtcShadowRegs shadowRegs (
		.clk(clk),
		.reset(reset),
		.writeEn(shadowWrite),
		.writeIndex(shadowIndex),
		.writeData(shadowData),
		.readIndex(readIndex),
		.readData(readData)
	);

endmodule

`default_nettype wire

// ==== verif/rtcChipModel.sv ====
`default_nettype none

module rtcChipModel (
	input logic clk,
	input logic csN,
	input logic adN,
	input logic rdN,
	input logic wrN,
	inout wire rtcPkg::rtcData_t dataBus
);
	timeunit 1ns;
	timeprecision 100ps;
	import rtcPkg::*;

	localparam int LOG_DEPTH = 64;

	// whole register space of the chip
	rtcData_t regs [256];
	rtcAddr_t addrLatch;
	rtcData_t pendingData;
	logic writeActive;

	// completed writes as {address, data}, oldest first
	logic [15:0] writeLog [LOG_DEPTH];
	int writeCount;

	initial begin
		for (int i = 0; i < 256; i++) begin
			regs[i] = '0;
		end
		addrLatch = '0;
		pendingData = '0;
		writeActive = 1'b0;
		writeCount = 0;
	end

	// chip only drives the bus while selected and read strobe low
	assign dataBus = (!csN && !rdN) ? regs[addrLatch] : 'z;

	always @(posedge clk) begin
		if (!csN && !adN) begin
			addrLatch <= dataBus;
		end
		if (!csN && !wrN) begin
			regs[addrLatch] <= dataBus;
			pendingData <= dataBus;
			writeActive <= 1'b1;
		end else if (writeActive) begin
			// one log entry per write, once the strobe is gone
			if (writeCount < LOG_DEPTH) begin
				writeLog[writeCount] <= {addrLatch, pendingData};
			end
			writeCount <= writeCount + 1;
			writeActive <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verif/rtcControllerProperties.sv ====
`default_nettype none

module rtcControllerProperties #(
	parameter int PHASE_CYCLES = 2
) (
	input logic clk,
	input logic reset,
	input logic csN,
	input logic rdN,
	input logic wrN,
	input logic busOe,
	input logic busDone,
	input logic accepted
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of assertion failures so far
	int failCount = 0;

	selectDuringStrobe: assert property (@(posedge clk) disable iff (reset)
		(!rdN || !wrN) |-> !csN)
		else begin
			$error("read or write strobe low while chip select is high");
			failCount++;
		end

	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(!rdN && !wrN))
		else begin
			$error("read and write strobes low in the same cycle");
			failCount++;
		end

	busReleasedOnRead: assert property (@(posedge clk) disable iff (reset)
		!rdN |-> !busOe)
		else begin
			$error("controller drives the bus while the chip is being read");
			failCount++;
		end

	// done only in the last cycle of the four phases
	doneTiming: assert property (@(posedge clk) disable iff (reset)
		accepted |-> ##1 (!busDone) [*(4 * PHASE_CYCLES - 1)] ##1 busDone)
		else begin
			$error("busDone not exactly four phases after an accepted start");
			failCount++;
		end

endmodule

bind rtcBusPhy rtcControllerProperties #(
	.PHASE_CYCLES(PHASE_CYCLES)
) props (
	.clk(clk),
	.reset(reset),
	.csN(csN),
	.rdN(rdN),
	.wrN(wrN),
	.busOe(busOe),
	.busDone(busDone),
	.accepted(busStart && (phase == IDLE))
);

`default_nettype wire

// ==== verif/rtcControllerTb.sv ====
`default_nettype none

module rtcControllerTb;
	timeunit 1ns;
	timeprecision 100ps;
	import rtcPkg::*;

	localparam int PHASE_CYCLES = 2;
	localparam int CLK_PERIOD = 8;
	localparam int NUM_TESTS = 5;
	// one transaction plus the issue and wait cycles around it
	localparam int TRANS_CYCLES = 4 * PHASE_CYCLES + 2;
	localparam int SWEEP_CYCLES = 6 * TRANS_CYCLES + 2;
	localparam int INIT_LIMIT = 3 * TRANS_CYCLES + 10;
	localparam int ACK_LIMIT = 2 * SWEEP_CYCLES + TRANS_CYCLES;
	localparam int WATCHDOG_NS = NUM_TESTS * 20 * SWEEP_CYCLES * CLK_PERIOD;
	localparam rtcAddr_t SECONDS_ADDR = 8'h21;
	localparam rtcAddr_t MINUTES_ADDR = 8'h22;
	localparam rtcAddr_t HOURS_ADDR = 8'h23;

	logic clk;
	logic reset;
	logic userWrite;
	rtcAddr_t userAddr;
	rtcData_t userData;
	regIndex_t readIndex;
	wire rtcData_t dataBus;
	logic csN;
	logic adN;
	logic rdN;
	logic wrN;
	logic userAck;
	logic initDone;
	logic sweepDone;
	rtcData_t readData;

	logic [31:0] lfsrState;
	string testName;
	int errorCount;
	int testErrors;
	int testsRun;
	rtcData_t timeValues [6];

	rtcController #(
		.PHASE_CYCLES(PHASE_CYCLES)
	) dut (
		.clk(clk),
		.reset(reset),
		.csN(csN),
		.adN(adN),
		.rdN(rdN),
		.wrN(wrN),
		.dataBus(dataBus),
		.userWrite(userWrite),
		.userAddr(userAddr),
		.userData(userData),
		.userAck(userAck),
		.readIndex(readIndex),
		.readData(readData),
		.initDone(initDone),
		.sweepDone(sweepDone)
	);

	rtcChipModel chip (
		.clk(clk),
		.csN(csN),
		.adN(adN),
		.rdN(rdN),
		.wrN(wrN),
		.dataBus(dataBus)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic drawByte(output rtcData_t value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errorCount == testErrors) begin
			$display("test %s: passed", testName);
		end else begin
			$display("test %s: failed with %0d errors", testName, errorCount - testErrors);
		end
	endtask

	task automatic reportMismatch(input string what, input int expected, input int actual);
		errorCount++;
		$display("error %s %s: expected %0h, actual %0h", testName, what, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("%s: %s", testName, what);
	endtask

	task automatic nextSweepDone(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < 2 * SWEEP_CYCLES) begin
			@(negedge clk);
			seen = sweepDone;
			cycles++;
		end
		if (!seen) begin
			reportFailure("no sweepDone pulse within the sweep time limit");
		end
	endtask

	task automatic waitUserAck(output logic acked);
		int cycles;
		acked = 1'b0;
		cycles = 0;
		while (!acked && cycles < ACK_LIMIT) begin
			@(negedge clk);
			acked = userAck;
			cycles++;
		end
		if (!acked) begin
			reportFailure("userAck never arrived for the pending write");
		end
	endtask

	task automatic readShadow(input regIndex_t index, output rtcData_t value);
		@(posedge clk);
		readIndex <= index;
		@(negedge clk);
		value = readData;
	endtask

	task automatic resetStrobes();
		startTest("reset");
		reset = 1'b1;
		repeat (7) begin
			@(negedge clk);
			if ({csN, adN, rdN, wrN} !== 4'hf) begin
				reportMismatch("strobes", 4'hf, {csN, adN, rdN, wrN});
			end
			if (initDone !== 1'b0) begin
				reportMismatch("initDone", 0, initDone);
			end
		end
		// eighth rising edge still sees reset high
		@(posedge clk);
		reset <= 1'b0;
		endTest();
	endtask

	task automatic initTable();
		rtcAddr_t expAddr [3] = '{8'h02, 8'h01, 8'h02};
		rtcData_t expData [3] = '{8'h10, 8'h00, 8'h00};
		logic done;
		int cycles;
		startTest("init");
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < INIT_LIMIT) begin
			@(negedge clk);
			done = initDone;
			cycles++;
		end
		if (!done) begin
			reportFailure("initDone did not rise after the init writes");
		end
		if (chip.writeCount != 3) begin
			reportMismatch("write count", 3, chip.writeCount);
		end
		for (int i = 0; i < 3; i++) begin
			if (chip.writeLog[i] !== {expAddr[i], expData[i]}) begin
				reportMismatch($sformatf("write %0d", i), {expAddr[i], expData[i]},
					chip.writeLog[i]);
			end
		end
		endTest();
	endtask

	task automatic pollSweeps();
		logic seen;
		rtcData_t shadow;
		startTest("polling");
		@(negedge clk);
		for (int n = 0; n < 6; n++) begin
			drawByte(timeValues[n]);
			chip.regs[SECONDS_ADDR + n] = timeValues[n];
		end
		// the first sweep may have started before the load
		nextSweepDone(seen);
		nextSweepDone(seen);
		for (int n = 0; n < 6; n++) begin
			readShadow(regIndex_t'(n), shadow);
			if (shadow !== timeValues[n]) begin
				reportMismatch($sformatf("shadow %0d", n), timeValues[n], shadow);
			end
		end
		endTest();
	endtask

	task automatic userWriteThrough();
		rtcData_t value;
		rtcData_t shadow;
		int countBefore;
		logic acked;
		logic seen;
		startTest("user write");
		drawByte(value);
		countBefore = chip.writeCount;
		@(posedge clk);
		userWrite <= 1'b1;
		userAddr <= MINUTES_ADDR;
		userData <= value;
		waitUserAck(acked);
		@(posedge clk);
		userWrite <= 1'b0;
		if (chip.regs[MINUTES_ADDR] !== value) begin
			reportMismatch("chip minutes", value, chip.regs[MINUTES_ADDR]);
		end
		if (chip.writeCount != countBefore + 1) begin
			reportMismatch("write count", countBefore + 1, chip.writeCount);
		end
		// sweep right after the ack is the first full one with the new value
		nextSweepDone(seen);
		readShadow(regIndex_t'(1), shadow);
		if (shadow !== value) begin
			reportMismatch("shadow minutes", value, shadow);
		end
		endTest();
	endtask

	task automatic backPressure();
		rtcData_t value;
		int countBefore;
		int cycles;
		logic seen;
		logic acked;
		logic sweepSeen;
		logic early;
		logic late;
		startTest("back-pressure");
		drawByte(value);
		nextSweepDone(seen);
		// well inside the next sweep
		repeat (SWEEP_CYCLES / 3) @(posedge clk);
		countBefore = chip.writeCount;
		userWrite <= 1'b1;
		userAddr <= HOURS_ADDR;
		userData <= value;
		acked = 1'b0;
		sweepSeen = 1'b0;
		early = 1'b0;
		late = 1'b0;
		cycles = 0;
		while (!acked && cycles < ACK_LIMIT) begin
			@(negedge clk);
			cycles++;
			acked = userAck;
			if (userAck && !sweepSeen) begin
				early = 1'b1;
			end
			if (sweepDone) begin
				if (sweepSeen) begin
					late = 1'b1;
				end
				sweepSeen = 1'b1;
			end
		end
		@(posedge clk);
		userWrite <= 1'b0;
		if (!acked) begin
			reportFailure("userAck never arrived for a request held from mid-sweep");
		end
		if (early) begin
			reportFailure("userAck came before the running sweep had finished");
		end
		if (late) begin
			reportFailure("userAck did not follow the end of the running sweep");
		end
		// one more sweep so that a repeated write would show up
		nextSweepDone(seen);
		if (chip.writeCount != countBefore + 1) begin
			reportMismatch("write count", countBefore + 1, chip.writeCount);
		end
		if (chip.regs[HOURS_ADDR] !== value) begin
			reportMismatch("chip hours", value, chip.regs[HOURS_ADDR]);
		end
		endTest();
	endtask

	initial begin
		reset = 1'b1;
		userWrite = 1'b0;
		userAddr = '0;
		userData = '0;
		readIndex = '0;
		lfsrState = 32'h3527_2e5c;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		resetStrobes();
		initTable();
		pollSweeps();
		userWriteThrough();
		backPressure();
		if (dut.busPhy.props.failCount != 0) begin
			errorCount += dut.busPhy.props.failCount;
			$display("%0d bus protocol assertions failed", dut.busPhy.props.failCount);
		end
		$display("%0d tests run, %0d errors", testsRun, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtcController.f ====
design/rtcPkg.sv
design/rtcBusPhy.sv
design/rtcInit.sv
design/rtcPoller.sv
design/rtcSequencer.sv
design/rtcShadowRegs.sv
design/rtcController.sv
verif/rtcChipModel.sv
verif/rtcControllerProperties.sv
verif/rtcControllerTb.sv

// ==== Bender.yml ====
package:
  name: rtc_controller

sources:
  - files:
      - design/rtcPkg.sv
      - design/rtcBusPhy.sv
      - design/rtcInit.sv
      - design/rtcPoller.sv
      - design/rtcSequencer.sv
      - design/rtcShadowRegs.sv
      - design/rtcController.sv
  - target: test
    files:
      - verif/rtcChipModel.sv
      - verif/rtcControllerProperties.sv
      - verif/rtcControllerTb.sv
